// ==== rtl/sw_pkg.sv ====
package sw_pkg;

	// array and buffer sizes
	localparam int NUM_PE   = 4;
	localparam int T_MAX    = 16;
	localparam int T_CNT_W  = 5;
	localparam int T_ADDR_W = $clog2(T_MAX);
	localparam int SCORE_W  = 10;

	typedef logic [1:0] base_t;
	typedef logic signed [SCORE_W-1:0] score_t;

	// penalties are unsigned magnitudes
	typedef struct packed {
		base_t [NUM_PE-1:0] query;
		logic [3:0]         match;
		logic [3:0]         mismatch;
		logic [3:0]         gap_open;
		logic [3:0]         gap_ext;
	} align_cfg_t;

	// one row of the matrix moving right through the array
	typedef struct packed {
		logic   valid;
		logic   last;
		base_t  t;
		score_t h;
		score_t f;
	} cell_tok_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD_T,
		CALC,
		FINISH
	} ctrl_state_e;

	localparam align_cfg_t CFG_RESET = '{
		query:    '0,
		match:    4'd2,
		mismatch: 4'd1,
		gap_open: 4'd2,
		gap_ext:  4'd1
	};

endpackage

// ==== rtl/target_buffer.sv ====
`timescale 1ns/1ps

module target_buffer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        i_clear,
	input  logic                        i_wr,
	input  sw_pkg::base_t               i_wr_base,
	input  logic [sw_pkg::T_ADDR_W-1:0] i_rd_addr,
	output sw_pkg::base_t               o_rd_base,
	output logic [sw_pkg::T_CNT_W-1:0]  o_count
);

	sw_pkg::base_t mem [sw_pkg::T_MAX];
	logic          full;

	assign full = (o_count == sw_pkg::T_CNT_W'(sw_pkg::T_MAX));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_count <= '0;
		end else if (i_clear) begin
			o_count <= '0;
		end else if (i_wr && !full) begin
			o_count <= o_count + sw_pkg::T_CNT_W'(1);
		end
	end

	// extra bases beyond the buffer depth are dropped
	always_ff @(posedge clk) begin
		if (i_wr && !i_clear && !full)
			mem[o_count[sw_pkg::T_ADDR_W-1:0]] <= i_wr_base;
	end

	assign o_rd_base = mem[i_rd_addr];

	a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
		o_count <= sw_pkg::T_CNT_W'(sw_pkg::T_MAX));

endmodule

// ==== rtl/target_feeder.sv ====
`timescale 1ns/1ps

module target_feeder (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        i_start,
	input  logic [sw_pkg::T_CNT_W-1:0]  i_count,
	output logic [sw_pkg::T_ADDR_W-1:0] o_rd_addr,
	input  sw_pkg::base_t               i_rd_base,
	output sw_pkg::cell_tok_t           o_tok
);

	logic [sw_pkg::T_CNT_W-1:0] ptr;
	logic [sw_pkg::T_CNT_W-1:0] ptr_inc;
	logic                       active;
	logic                       emit;
	logic                       is_last;

	// ptr rests at zero between runs so the first read needs no setup
	assign o_rd_addr = ptr[sw_pkg::T_ADDR_W-1:0];
	assign ptr_inc   = ptr + sw_pkg::T_CNT_W'(1);
	assign emit      = i_start || active;
	assign is_last   = (ptr_inc == i_count);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr    <= '0;
			active <= 1'b0;
			o_tok  <= '0;
		end else if (emit) begin
			o_tok.valid <= 1'b1;
			o_tok.last  <= is_last;
			o_tok.t     <= i_rd_base;
			// left boundary of the matrix
			o_tok.h     <= '0;
			o_tok.f     <= '0;
			if (is_last) begin
				ptr    <= '0;
				active <= 1'b0;
			end else begin
				ptr    <= ptr_inc;
				active <= 1'b1;
			end
		end else begin
			o_tok.valid <= 1'b0;
			o_tok.last  <= 1'b0;
		end
	end

	a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		i_start |-> !active);

endmodule

// ==== rtl/align_cell.sv ====
`timescale 1ns/1ps

module align_cell (
	input  logic               clk,
	input  logic               rst_n,
	input  sw_pkg::base_t      i_query,
	input  sw_pkg::align_cfg_t i_cfg,
	input  sw_pkg::cell_tok_t  i_tok,
	output sw_pkg::cell_tok_t  o_tok
);

	sw_pkg::score_t diag_q;
	sw_pkg::score_t e_q;
	sw_pkg::score_t diag;
	sw_pkg::score_t h_up;
	sw_pkg::score_t e_up;
	sw_pkg::score_t gap_open;
	sw_pkg::score_t gap_ext;
	sw_pkg::score_t sub;
	sw_pkg::score_t e_new;
	sw_pkg::score_t f_new;
	sw_pkg::score_t h_new;
	logic           first;

	function automatic sw_pkg::score_t smax(input sw_pkg::score_t a, input sw_pkg::score_t b);
		return (a > b) ? a : b;
	endfunction

	// o_tok still holds the previous token, so its valid marks a run in progress
	assign first = i_tok.valid && !o_tok.valid;

	assign diag = first ? '0 : diag_q;
	assign h_up = first ? '0 : o_tok.h;
	assign e_up = first ? '0 : e_q;

	assign gap_open = sw_pkg::score_t'(i_cfg.gap_open);
	assign gap_ext  = sw_pkg::score_t'(i_cfg.gap_ext);
	assign sub      = (i_query == i_tok.t) ? sw_pkg::score_t'(i_cfg.match) :
		-sw_pkg::score_t'(i_cfg.mismatch);

	assign e_new = smax(h_up - gap_open, e_up - gap_ext);
	assign f_new = smax(i_tok.h - gap_open, i_tok.f - gap_ext);
	assign h_new = smax(smax(sw_pkg::score_t'(0), diag + sub), smax(e_new, f_new));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_tok <= '0;
		end else begin
			o_tok.valid <= i_tok.valid;
			o_tok.last  <= i_tok.valid && i_tok.last;
			if (i_tok.valid) begin
				o_tok.t <= i_tok.t;
				o_tok.h <= h_new;
				o_tok.f <= f_new;
			end
		end
	end

	// column state carried to the next row
	always_ff @(posedge clk) begin
		if (i_tok.valid) begin
			diag_q <= i_tok.h;
			e_q    <= e_new;
		end
	end

	a_h_nonneg: assert property (@(posedge clk) disable iff (!rst_n)
		o_tok.valid |-> (o_tok.h >= 0));

endmodule

// ==== rtl/cell_array.sv ====
`timescale 1ns/1ps

module cell_array (
	input  logic                      clk,
	input  logic                      rst_n,
	input  sw_pkg::align_cfg_t        i_cfg,
	input  sw_pkg::cell_tok_t         i_tok,
	output sw_pkg::score_t            o_score [sw_pkg::NUM_PE],
	output logic [sw_pkg::NUM_PE-1:0] o_score_valid,
	output logic                      o_last_out
);

	// tok[g] feeds cell g, tok[NUM_PE] leaves the array
	sw_pkg::cell_tok_t tok [sw_pkg::NUM_PE+1];

	assign tok[0] = i_tok;

	for (genvar g = 0; g < sw_pkg::NUM_PE; g++) begin : g_cell
		align_cell align_cell_i (
			.clk     (clk),
			.rst_n   (rst_n),
			.i_query (i_cfg.query[g]),
			.i_cfg   (i_cfg),
			.i_tok   (tok[g]),
			.o_tok   (tok[g+1])
		);

		assign o_score[g]       = tok[g+1].h;
		assign o_score_valid[g] = tok[g+1].valid;
	end

	assign o_last_out = tok[sw_pkg::NUM_PE].valid && tok[sw_pkg::NUM_PE].last;

endmodule

// ==== rtl/score_collector.sv ====
`timescale 1ns/1ps

module score_collector (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      i_start,
	input  sw_pkg::score_t            i_score [sw_pkg::NUM_PE],
	input  logic [sw_pkg::NUM_PE-1:0] i_score_valid,
	input  logic                      i_last_out,
	output sw_pkg::score_t            o_result,
	output logic                      o_done
);

	sw_pkg::score_t max_q;
	sw_pkg::score_t max_next;

	// fold every cell that fired this cycle into the running best
	always_comb begin
		max_next = max_q;
		for (int k = 0; k < sw_pkg::NUM_PE; k++) begin
			if (i_score_valid[k] && (i_score[k] > max_next))
				max_next = i_score[k];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			max_q    <= '0;
			o_result <= '0;
			o_done   <= 1'b0;
		end else begin
			o_done <= i_last_out;
			if (i_start)
				max_q <= '0;
			else
				max_q <= max_next;
			// result holds until the next run ends
			if (i_last_out)
				o_result <= max_next;
		end
	end

endmodule

// ==== rtl/sw_top.sv ====
`timescale 1ns/1ps

module sw_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_set_t,
	input  logic                i_t_valid,
	input  sw_pkg::base_t       i_t,
	input  logic                i_t_last,
	input  sw_pkg::align_cfg_t  i_cfg,
	input  logic                i_cfg_valid,
	input  logic                i_start_cal,
	output logic                o_busy,
	output sw_pkg::score_t      o_result,
	output logic                o_valid
);

	sw_pkg::ctrl_state_e state_q;
	sw_pkg::ctrl_state_e state_d;
	sw_pkg::align_cfg_t  cfg_q;

	logic accept_load;
	logic accept_cal;
	logic start_q;
	logic buf_wr;
	logic done;

	logic [sw_pkg::T_CNT_W-1:0]  t_count;
	logic [sw_pkg::T_ADDR_W-1:0] rd_addr;
	sw_pkg::base_t               rd_base;
	sw_pkg::cell_tok_t           feed_tok;
	sw_pkg::score_t              cell_score [sw_pkg::NUM_PE];
	logic [sw_pkg::NUM_PE-1:0]   cell_valid;
	logic                        last_out;

	// a load request wins over a start in the same cycle
	assign accept_load = (state_q == sw_pkg::IDLE) && i_set_t;
	assign accept_cal  = (state_q == sw_pkg::IDLE) && !i_set_t && i_start_cal && (t_count != '0);
	assign buf_wr      = (state_q == sw_pkg::LOAD_T) && i_t_valid;

	always_comb begin
		state_d = state_q;
		case (state_q)
			sw_pkg::IDLE: begin
				if (accept_load)
					state_d = sw_pkg::LOAD_T;
				else if (accept_cal)
					state_d = sw_pkg::CALC;
			end
			sw_pkg::LOAD_T: begin
				if (i_t_valid && i_t_last)
					state_d = sw_pkg::IDLE;
			end
			sw_pkg::CALC: begin
				if (done)
					state_d = sw_pkg::FINISH;
			end
			default: state_d = sw_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= sw_pkg::IDLE;
			o_busy  <= 1'b0;
			start_q <= 1'b0;
			cfg_q   <= sw_pkg::CFG_RESET;
		end else begin
			state_q <= state_d;
			o_busy  <= (state_d != sw_pkg::IDLE);
			start_q <= accept_cal;
			// config stays frozen for the length of a run
			if (i_cfg_valid && (state_q != sw_pkg::CALC))
				cfg_q <= i_cfg;
		end
	end

	target_buffer target_buffer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_clear   (accept_load),
		.i_wr      (buf_wr),
		.i_wr_base (i_t),
		.i_rd_addr (rd_addr),
		.o_rd_base (rd_base),
		.o_count   (t_count)
	);

	target_feeder target_feeder_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_start   (start_q),
		.i_count   (t_count),
		.o_rd_addr (rd_addr),
		.i_rd_base (rd_base),
		.o_tok     (feed_tok)
	);

	cell_array cell_array_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_cfg         (cfg_q),
		.i_tok         (feed_tok),
		.o_score       (cell_score),
		.o_score_valid (cell_valid),
		.o_last_out    (last_out)
	);

	score_collector score_collector_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_start       (start_q),
		.i_score       (cell_score),
		.i_score_valid (cell_valid),
		.i_last_out    (last_out),
		.o_result      (o_result),
		.o_done        (done)
	);

	assign o_valid = done;

	// result pulse comes from the array, the state comes from here
	a_valid_in_calc: assert property (@(posedge clk) disable iff (!rst_n)
		o_valid |-> (state_q == sw_pkg::CALC));

endmodule

// ==== tests/tb_sw_top.sv ====
`timescale 1ns/1ps

module tb_sw_top;

	localparam int HALF_PERIOD = 20;
	localparam int STIM_DLY    = 2;
	localparam int TIMEOUT     = 100;

	logic               clk;
	logic               rst_n;
	logic               i_set_t;
	logic               i_t_valid;
	sw_pkg::base_t      i_t;
	logic               i_t_last;
	sw_pkg::align_cfg_t i_cfg;
	logic               i_cfg_valid;
	logic               i_start_cal;
	logic               o_busy;
	sw_pkg::score_t     o_result;
	logic               o_valid;

	sw_pkg::align_cfg_t latched_cfg;
	sw_pkg::align_cfg_t cfg_b;
	sw_pkg::score_t     exp_result;
	int                 tgt_model [sw_pkg::T_MAX];
	int                 tgt_len;
	int                 load_q [$];
	int                 err_count;
	int                 run_count;
	integer             seed;
	logic               run_open;
	logic               run_busy;

	sw_top sw_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_set_t     (i_set_t),
		.i_t_valid   (i_t_valid),
		.i_t         (i_t),
		.i_t_last    (i_t_last),
		.i_cfg       (i_cfg),
		.i_cfg_valid (i_cfg_valid),
		.i_start_cal (i_start_cal),
		.o_busy      (o_busy),
		.o_result    (o_result),
		.o_valid     (o_valid)
	);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	a_result: assert property (@(posedge clk) disable iff (!rst_n)
		o_valid |-> (o_result == exp_result))
		else begin
			err_count++;
			$display("Mismatch o_result: got %h expected %h", o_result, exp_result);
		end

	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		o_valid |=> !o_valid)
		else begin
			err_count++;
			$display("Mismatch o_valid: got %h expected 0", o_valid);
		end

	a_valid_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		o_valid |-> run_open)
		else begin
			err_count++;
			$display("o_valid pulsed while no run was started");
		end

	a_busy_run: assert property (@(posedge clk) disable iff (!rst_n)
		run_busy |-> o_busy)
		else begin
			err_count++;
			$display("Mismatch o_busy: got %h expected 1", o_busy);
		end

	// a start with nothing loaded must be dropped
	a_busy_empty: assert property (@(posedge clk) disable iff (!rst_n)
		(i_start_cal && (tgt_len == 0)) |=> !o_busy)
		else begin
			err_count++;
			$display("Mismatch o_busy: got %h expected 0", o_busy);
		end

	function automatic int larger(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	function automatic int rand_below(input int lim);
		return int'($unsigned($random(seed)) % lim);
	endfunction

	function automatic sw_pkg::align_cfg_t make_cfg(input int q0, input int q1, input int q2,
			input int q3, input int m, input int mm, input int go, input int ge);
		sw_pkg::align_cfg_t r;
		r.query[0] = sw_pkg::base_t'(q0);
		r.query[1] = sw_pkg::base_t'(q1);
		r.query[2] = sw_pkg::base_t'(q2);
		r.query[3] = sw_pkg::base_t'(q3);
		r.match    = 4'(m);
		r.mismatch = 4'(mm);
		r.gap_open = 4'(go);
		r.gap_ext  = 4'(ge);
		return r;
	endfunction

	// rows are target bases and columns are query bases
	function automatic int expected_score(input int len, input sw_pkg::align_cfg_t cfg);
		int h_prev [sw_pkg::NUM_PE];
		int h_row [sw_pkg::NUM_PE];
		int e_prev [sw_pkg::NUM_PE];
		int h_left;
		int f_left;
		int diag;
		int sub;
		int e_cur;
		int f_cur;
		int best;
		best = 0;
		for (int j = 0; j < sw_pkg::NUM_PE; j++) begin
			h_prev[j] = 0;
			e_prev[j] = 0;
		end
		for (int i = 0; i < len; i++) begin
			h_left = 0;
			f_left = 0;
			for (int j = 0; j < sw_pkg::NUM_PE; j++) begin
				diag  = (j == 0) ? 0 : h_prev[j-1];
				sub   = (int'(cfg.query[j]) == tgt_model[i]) ? int'(cfg.match) :
					-int'(cfg.mismatch);
				e_cur = larger(h_prev[j] - int'(cfg.gap_open), e_prev[j] - int'(cfg.gap_ext));
				f_cur = larger(h_left - int'(cfg.gap_open), f_left - int'(cfg.gap_ext));
				h_row[j]  = larger(larger(0, diag + sub), larger(e_cur, f_cur));
				e_prev[j] = e_cur;
				h_left    = h_row[j];
				f_left    = f_cur;
				best      = larger(best, h_row[j]);
			end
			h_prev = h_row;
		end
		return best;
	endfunction

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (o_busy && cycles < TIMEOUT) begin
			@(posedge clk);
			#STIM_DLY;
			cycles++;
		end
		assert (!o_busy) else begin
			err_count++;
			$display("timeout: o_busy never returned low");
		end
	endtask

	task automatic load_target();
		int n;
		n = load_q.size();
		i_set_t = 1'b1;
		@(posedge clk);
		#STIM_DLY;
		i_set_t = 1'b0;
		for (int k = 0; k < n; k++) begin
			i_t_valid = 1'b1;
			i_t       = sw_pkg::base_t'(load_q[k]);
			i_t_last  = (k == n - 1);
			@(posedge clk);
			#STIM_DLY;
		end
		i_t_valid = 1'b0;
		i_t_last  = 1'b0;
		wait_idle();
		tgt_len = (n > sw_pkg::T_MAX) ? sw_pkg::T_MAX : n;
		for (int k = 0; k < tgt_len; k++)
			tgt_model[k] = load_q[k];
	endtask

	task automatic write_cfg(input sw_pkg::align_cfg_t cfg);
		i_cfg       = cfg;
		i_cfg_valid = 1'b1;
		@(posedge clk);
		#STIM_DLY;
		i_cfg_valid = 1'b0;
		latched_cfg = cfg;
	endtask

	// cfg_mid holds a new config on the bus for the whole run
	task automatic run_check(input int exp, input logic cfg_mid,
			input sw_pkg::align_cfg_t cfg_new);
		int   cycles;
		logic seen;
		exp_result  = sw_pkg::score_t'(exp);
		run_open    = 1'b1;
		i_start_cal = 1'b1;
		@(posedge clk);
		#STIM_DLY;
		i_start_cal = 1'b0;
		run_busy    = 1'b1;
		if (cfg_mid) begin
			i_cfg       = cfg_new;
			i_cfg_valid = 1'b1;
		end
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < TIMEOUT) begin
			@(posedge clk);
			#STIM_DLY;
			cycles++;
			seen = o_valid;
		end
		assert (seen) else begin
			err_count++;
			$display("timeout: no o_valid after start");
		end
		assert (!seen || cycles == tgt_len + sw_pkg::NUM_PE + 1) else begin
			err_count++;
			$display("Mismatch o_valid latency: got %h expected %h", cycles,
				tgt_len + sw_pkg::NUM_PE + 1);
		end
		@(posedge clk);
		#STIM_DLY;
		run_open = 1'b0;
		run_busy = 1'b0;
		wait_idle();
		if (cfg_mid) begin
			i_cfg_valid = 1'b0;
			latched_cfg = cfg_new;
		end
		run_count++;
	endtask

	task automatic run_model();
		run_check(expected_score(tgt_len, latched_cfg), 1'b0, latched_cfg);
	endtask

	initial begin
		int n;
		rst_n       = 1'b0;
		i_set_t     = 1'b0;
		i_t_valid   = 1'b0;
		i_t         = '0;
		i_t_last    = 1'b0;
		i_cfg       = '0;
		i_cfg_valid = 1'b0;
		i_start_cal = 1'b0;
		exp_result  = '0;
		tgt_len     = 0;
		err_count   = 0;
		run_count   = 0;
		seed        = 74;
		run_open    = 1'b0;
		run_busy    = 1'b0;
		latched_cfg = make_cfg(0, 0, 0, 0, 2, 1, 2, 1);
		repeat (2) @(posedge clk);
		#STIM_DLY;
		rst_n = 1'b1;

		assert (!o_busy && !o_valid) else begin
			err_count++;
			$display("Mismatch o_busy/o_valid after reset: got %h %h", o_busy, o_valid);
		end

		// empty buffer, start is ignored
		i_start_cal = 1'b1;
		@(posedge clk);
		#STIM_DLY;
		i_start_cal = 1'b0;
		repeat (4) @(posedge clk);
		#STIM_DLY;

		load_q = '{0, 0, 1, 0, 0, 0, 2, 0};
		load_target();
		run_model();

		write_cfg(make_cfg(1, 2, 3, 0, 3, 2, 3, 1));
		load_q = '{3, 3, 1, 2, 3, 0, 2, 2};
		load_target();
		run_check(12, 1'b0, latched_cfg);
		cfg_b = make_cfg(1, 2, 3, 0, 7, 2, 3, 1);
		run_check(12, 1'b1, cfg_b);
		run_check(28, 1'b0, latched_cfg);

		write_cfg(make_cfg(0, 0, 0, 0, 3, 2, 3, 1));
		load_q = '{1, 2, 3, 3, 2, 1};
		load_target();
		run_check(0, 1'b0, latched_cfg);

		// two extra target bases force a gap of length two in the query
		write_cfg(make_cfg(0, 1, 2, 3, 5, 4, 3, 1));
		load_q = '{0, 1, 2, 2, 2, 3};
		load_target();
		run_check(16, 1'b0, latched_cfg);

		// the bases past the buffer depth spell out the query
		load_q.delete();
		repeat (sw_pkg::T_MAX) load_q.push_back(3);
		for (int k = 0; k < sw_pkg::NUM_PE; k++)
			load_q.push_back(k);
		load_target();
		run_model();
		load_q = '{0, 1, 1, 2, 3};
		load_target();
		run_model();

		repeat (20) begin
			n = 1 + rand_below(sw_pkg::T_MAX);
			load_q.delete();
			repeat (n) load_q.push_back(rand_below(4));
			load_target();
			write_cfg(make_cfg(rand_below(4), rand_below(4), rand_below(4), rand_below(4),
				rand_below(16), rand_below(16), rand_below(16), rand_below(16)));
			run_model();
		end

		$display("runs: %0d, errors: %0d", run_count, err_count);
		if (err_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
rtl/sw_pkg.sv
rtl/target_buffer.sv
rtl/target_feeder.sv
rtl/align_cell.sv
rtl/cell_array.sv
rtl/score_collector.sv
rtl/sw_top.sv
tests/tb_sw_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_sw_top
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
